// ==== ddmtd_capture.f ====
verilog/ddmtd_pkg.sv
verilog/ddmtd_sequencer.sv
verilog/ddmtd_timebase.sv
verilog/edge_stamper.sv
verilog/capture_writer.sv
verilog/ddmtd_capture_top.sv
verification/tb_ddmtd_capture.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the DDMTD capture testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_ddmtd_capture \
  -f ddmtd_capture.f \
  -o tb_ddmtd_capture \
  && ./obj_dir/tb_ddmtd_capture > sim.log 2>&1

cat sim.log 2>/dev/null

grep -Fqx "Simulation passed" sim.log 2>/dev/null \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }

// ==== verification/tb_ddmtd_capture.sv ====
`timescale 1ns/1ps

module tb_ddmtd_capture;

  localparam int NUM_CH        = 5;
  localparam int SETTLE_CYCLES = 30;
  localparam int ARM_CYCLES    = 20;
  localparam int BEAT_HALF     = 40;
  localparam int DEPTH         = 16;
  localparam int MAX_RISES     = 64;

  logic              clk_ref;
  logic              user_reset;
  logic [NUM_CH-1:0] ddmtd_q;
  logic              capture_go;
  logic [4:0]        words_to_send;
  logic [3:0]        rd_addr;
  logic [NUM_CH:0]   rd_mask;
  logic [31:0]       rd_stamp;
  logic [4:0]        words_written;
  logic              armed;
  logic              capturing;
  logic              capture_done;
  logic              beat_out;

  int    seed;
  int    errors;
  int    errors_at_start;
  int    tests_run;
  int    tests_failed;
  string test_name;
  int    cycle_count = 0;
  // drive cycle of every rising edge on each channel
  int    rise_cycle [NUM_CH][MAX_RISES];
  int    rise_cnt [NUM_CH];

  ddmtd_capture_top #(
    .NUM_CHANNELS  (NUM_CH),
    .SETTLE_CYCLES (SETTLE_CYCLES),
    .ARM_CYCLES    (ARM_CYCLES),
    .BEAT_HALF     (BEAT_HALF),
    .DEPTH         (DEPTH)
  ) ddmtd_capture_top_inst (
    .clk_ref       (clk_ref),
    .user_reset    (user_reset),
    .ddmtd_q       (ddmtd_q),
    .capture_go    (capture_go),
    .words_to_send (words_to_send),
    .rd_addr       (rd_addr),
    .rd_mask       (rd_mask),
    .rd_stamp      (rd_stamp),
    .words_written (words_written),
    .armed         (armed),
    .capturing     (capturing),
    .capture_done  (capture_done),
    .beat_out      (beat_out)
  );

  // 8 ns reference clock
  initial begin
    clk_ref = 1'b0;
    forever #4 clk_ref = ~clk_ref;
  end

  // count of rising edges used to time the drives
  always @(posedge clk_ref) begin
    cycle_count <= cycle_count + 1;
  end

  // done means the word count sits exactly at the request
  assert property (@(posedge clk_ref) disable iff (user_reset)
    capture_done |-> (words_written == words_to_send))
    else begin
      $display("[ERROR] words_written at done: got 0x%0h, expected 0x%0h",
               words_written, words_to_send);
      errors++;
    end

  // ========================================
  // check and report helpers
  // ========================================

  task automatic check_hex(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
      end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test;
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  // ========================================
  // stimulus helpers called at a falling edge
  // ========================================

  // 3 cycles of reset with outputs checked in the first cycle
  task automatic apply_reset;
    user_reset = 1'b1;
    @(negedge clk_ref);
    check_hex("armed", 32'(armed), 32'h0);
    check_hex("capturing", 32'(capturing), 32'h0);
    check_hex("capture_done", 32'(capture_done), 32'h0);
    check_hex("words_written", 32'(words_written), 32'h0);
    check_hex("beat_out", 32'(beat_out), 32'h0);
    repeat (2) @(negedge clk_ref);
    user_reset = 1'b0;
  endtask

  // hold plus settle counted from reset release
  task automatic check_arming;
    int cycles;
    cycles = 0;
    while (!armed && (cycles < 200)) begin
      @(negedge clk_ref);
      cycles++;
    end
    if (!armed) begin
      $display("armed never rose within 200 cycles of reset release");
      errors++;
    end else begin
      check_hex("armed delay", 32'(cycles), 32'(SETTLE_CYCLES + ARM_CYCLES));
    end
  endtask

  task automatic wait_beat_toggle(output int cycles);
    logic start_level;
    start_level = beat_out;
    cycles = 0;
    while ((beat_out == start_level) && (cycles < 4 * BEAT_HALF)) begin
      @(negedge clk_ref);
      cycles++;
    end
    if (beat_out == start_level) begin
      $display("beat_out stopped toggling");
      errors++;
    end
  endtask

  task automatic wait_capturing;
    int cycles;
    cycles = 0;
    while (!capturing && (cycles < 10)) begin
      @(negedge clk_ref);
      cycles++;
    end
    if (!capturing) begin
      $display("capture did not start after capture_go went high");
      errors++;
    end
  endtask

  task automatic clear_rises;
    for (int c = 0; c < NUM_CH; c++) begin
      rise_cnt[c] = 0;
    end
  endtask

  // one channel high then low for random lengths
  task automatic pulse_random;
    int ch;
    int high_len;
    int low_len;
    ch       = int'($unsigned($random(seed)) % NUM_CH);
    high_len = 1 + int'($unsigned($random(seed)) % 4);
    low_len  = 1 + int'($unsigned($random(seed)) % 4);
    ddmtd_q[ch] = 1'b1;
    if (rise_cnt[ch] < MAX_RISES) begin
      rise_cycle[ch][rise_cnt[ch]] = cycle_count;
      rise_cnt[ch]++;
    end
    repeat (high_len) @(negedge clk_ref);
    ddmtd_q[ch] = 1'b0;
    repeat (low_len) @(negedge clk_ref);
  endtask

  // ========================================
  // read back and stamp checks
  // ========================================

  task automatic check_entries(input int count, input logic [31:0] floor_stamp,
                               output logic [31:0] last_stamp);
    logic [NUM_CH:0] mask;
    logic [31:0]     stamp;
    logic [31:0]     prev_stamp;
    logic [31:0]     prev_ch [NUM_CH];
    logic [31:0]     prev_beat;
    int              seen [NUM_CH];
    bit              have_beat;
    prev_stamp = floor_stamp;
    prev_beat  = '0;
    have_beat  = 1'b0;
    for (int c = 0; c < NUM_CH; c++) begin
      seen[c]    = 0;
      prev_ch[c] = '0;
    end
    for (int i = 0; i < count; i++) begin
      // registered read returns data one cycle after the address
      rd_addr = 4'(i);
      @(negedge clk_ref);
      mask  = rd_mask;
      stamp = rd_stamp;
      assert (mask != '0)
        else begin
          $display("[ERROR] rd_mask entry %0d: got 0x%0h, expected nonzero", i, mask);
          errors++;
        end
      assert (stamp > prev_stamp)
        else begin
          $display("[ERROR] rd_stamp entry %0d: got 0x%0h, expected above 0x%0h",
                   i, stamp, prev_stamp);
          errors++;
        end
      for (int c = 0; c < NUM_CH; c++) begin
        if (((mask >> c) & 6'd1) != 6'd0) begin
          if (seen[c] >= rise_cnt[c]) begin
            $display("entry %0d holds an edge on channel %0d that was never driven", i, c);
            errors++;
          end else begin
            // stamp gap equals drive gap
            if (seen[c] > 0) begin
              check_hex($sformatf("rd_stamp gap ch%0d", c), stamp - prev_ch[c],
                        rise_cycle[c][seen[c]] - rise_cycle[c][seen[c] - 1]);
            end
            prev_ch[c] = stamp;
            seen[c]++;
          end
        end
      end
      // beat rises a full period apart
      if (mask[NUM_CH]) begin
        if (have_beat) begin
          check_hex("rd_stamp gap beat", stamp - prev_beat, 32'(2 * BEAT_HALF));
        end
        prev_beat = stamp;
        have_beat = 1'b1;
      end
      prev_stamp = stamp;
    end
    last_stamp = prev_stamp;
  endtask

  // ========================================
  // test sequence
  // ========================================

  initial begin
    int          len;
    int          pulses;
    int          cycles;
    logic [31:0] last_stamp;
    user_reset    = 1'b1;
    ddmtd_q       = '0;
    capture_go    = 1'b0;
    words_to_send = 5'd16;
    rd_addr       = '0;
    seed          = 32'hea8c_14a9;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    clear_rises();
    @(negedge clk_ref);

    start_test("reset_and_arming");
    apply_reset();
    check_arming();
    finish_test();

    start_test("beat_period");
    // first toggle only aligns to a level boundary
    wait_beat_toggle(len);
    repeat (2) begin
      wait_beat_toggle(len);
      check_hex("beat_out level length", 32'(len), 32'(BEAT_HALF));
    end
    finish_test();

    start_test("capture_and_stamps");
    capture_go = 1'b1;
    wait_capturing();
    clear_rises();
    pulses = 0;
    while (!capture_done && (pulses < 200)) begin
      pulse_random();
      pulses++;
    end
    if (!capture_done) begin
      $display("capture_done never rose after 200 channel pulses");
      errors++;
    end
    check_entries(DEPTH, 32'h0, last_stamp);
    finish_test();

    start_test("word_limit");
    // edges keep coming from channels and beat
    repeat (6) pulse_random();
    repeat (2 * BEAT_HALF + 4) @(negedge clk_ref);
    check_hex("capture_done", 32'(capture_done), 32'h1);
    check_hex("words_written", 32'(words_written), 32'h10);
    finish_test();

    start_test("rearm_and_reset");
    capture_go = 1'b0;
    @(negedge clk_ref);
    check_hex("capture_done", 32'(capture_done), 32'h0);
    check_hex("words_written", 32'(words_written), 32'h0);
    capture_go = 1'b1;
    wait_capturing();
    clear_rises();
    repeat (4) pulse_random();
    cycles = 0;
    while ((words_written < 5'd4) && (cycles < 20)) begin
      @(negedge clk_ref);
      cycles++;
    end
    if (words_written < 5'd4) begin
      $display("second capture stored fewer than 4 entries");
      errors++;
    end
    // new entries lie after the first capture
    check_entries(int'(words_written), last_stamp, last_stamp);
    check_hex("capturing", 32'(capturing), 32'h1);
    // capture_go stays high so only the reset can stop the capture
    apply_reset();
    check_arming();
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/capture_writer.sv ====
`timescale 1ns/1ps

module capture_writer #(
  parameter int NUM_CHANNELS = 5,
  parameter int DEPTH        = 1024
) (
  input  logic                     clk_ref,
  input  logic                     user_reset,
  input  logic                     write_en,
  input  logic                     clear,
  input  logic                     edge_valid,
  input  logic [NUM_CHANNELS:0]    edge_mask,
  input  ddmtd_pkg::stamp_t        edge_stamp,
  input  logic [$clog2(DEPTH):0]   words_to_send,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic                     limit_hit,
  output logic [$clog2(DEPTH):0]   words_written,
  output logic [NUM_CHANNELS:0]    rd_mask,
  output ddmtd_pkg::stamp_t        rd_stamp
);

  import ddmtd_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] MAX_WORDS = (AW + 1)'(DEPTH);

  // entry memory with mask and stamp side by side
  logic [NUM_CHANNELS:0] mem_mask [DEPTH];
  stamp_t                mem_stamp [DEPTH];

  logic [AW:0]   limit;
  logic [AW-1:0] wr_addr;
  logic          do_write;

  // ========================================
  // word limit
  // ========================================

  // requested count capped at memory size
  assign limit     = (words_to_send > MAX_WORDS) ? MAX_WORDS : words_to_send;
  assign limit_hit = (words_written >= limit);

  // ========================================
  // write side
  // ========================================

  // next free slot is the running word count
  assign wr_addr  = words_written[AW-1:0];
  assign do_write = edge_valid && write_en && !limit_hit;

  always_ff @(posedge clk_ref) begin
    if (user_reset || clear) begin
      words_written <= '0;
    end else if (do_write) begin
      words_written <= words_written + 1'b1;
    end
  end

  always_ff @(posedge clk_ref) begin
    if (do_write) begin
      mem_mask[wr_addr]  <= edge_mask;
      mem_stamp[wr_addr] <= edge_stamp;
    end
  end

  // ========================================
  // read port
  // ========================================

  // one cycle from rd_addr to data
  always_ff @(posedge clk_ref) begin
    rd_mask  <= mem_mask[rd_addr];
    rd_stamp <= mem_stamp[rd_addr];
  end

  // count moves only by one, only below the limit, only on a stamped edge
  assert property (@(posedge clk_ref) disable iff (user_reset)
    (!$past(user_reset) && !$past(clear) && (words_written != $past(words_written)))
    |-> (($past(words_written) < $past(limit)) && $past(edge_valid && write_en) &&
         (words_written == $past(words_written) + 1'b1)));

endmodule

// ==== verilog/ddmtd_capture_top.sv ====
`timescale 1ns/1ps

module ddmtd_capture_top #(
  parameter int NUM_CHANNELS  = 5,
  parameter int SETTLE_CYCLES = 950000,
  parameter int ARM_CYCLES    = 50000,
  parameter int BEAT_HALF     = 50000,
  parameter int DEPTH         = 1024
) (
  input  logic                     clk_ref,
  input  logic                     user_reset,
  input  logic [NUM_CHANNELS-1:0]  ddmtd_q,
  input  logic                     capture_go,
  input  logic [$clog2(DEPTH):0]   words_to_send,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [NUM_CHANNELS:0]    rd_mask,
  output ddmtd_pkg::stamp_t        rd_stamp,
  output logic [$clog2(DEPTH):0]   words_written,
  output logic                     armed,
  output logic                     capturing,
  output logic                     capture_done,
  output logic                     beat_out
);

  import ddmtd_pkg::*;

  // sequencer <-> timebase
  seq_state_t state;
  logic       phase_clear;
  logic       sampling_en;
  stamp_t     phase_count;

  // timebase -> stamper
  stamp_t stamp_now;
  logic   beat_ref;

  // stamper -> writer
  logic                  edge_valid;
  logic [NUM_CHANNELS:0] edge_mask;
  stamp_t                edge_stamp;

  // sequencer <-> writer
  logic write_en;
  logic clear;
  logic limit_hit;

  // ========================================
  // power-up and capture control
  // ========================================

  ddmtd_sequencer #(
    .SETTLE_CYCLES (SETTLE_CYCLES),
    .ARM_CYCLES    (ARM_CYCLES)
  ) ddmtd_sequencer_inst (
    .clk_ref      (clk_ref),
    .user_reset   (user_reset),
    .capture_go   (capture_go),
    .limit_hit    (limit_hit),
    .phase_count  (phase_count),
    .state        (state),
    .phase_clear  (phase_clear),
    .sampling_en  (sampling_en),
    .write_en     (write_en),
    .clear        (clear),
    .armed        (armed),
    .capturing    (capturing),
    .capture_done (capture_done)
  );

  // ========================================
  // counters and reference beat
  // ========================================

  ddmtd_timebase #(
    .BEAT_HALF (BEAT_HALF)
  ) ddmtd_timebase_inst (
    .clk_ref     (clk_ref),
    .user_reset  (user_reset),
    .state       (state),
    .phase_clear (phase_clear),
    .sampling_en (sampling_en),
    .phase_count (phase_count),
    .stamp_now   (stamp_now),
    .beat_ref    (beat_ref)
  );

  // beat also leaves the chip
  assign beat_out = beat_ref;

  // ========================================
  // edge stamping and storage
  // ========================================

  edge_stamper #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) edge_stamper_inst (
    .clk_ref     (clk_ref),
    .user_reset  (user_reset),
    .ddmtd_q     (ddmtd_q),
    .beat_ref    (beat_ref),
    .sampling_en (sampling_en),
    .stamp_now   (stamp_now),
    .edge_valid  (edge_valid),
    .edge_mask   (edge_mask),
    .edge_stamp  (edge_stamp)
  );

  capture_writer #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .DEPTH        (DEPTH)
  ) capture_writer_inst (
    .clk_ref       (clk_ref),
    .user_reset    (user_reset),
    .write_en      (write_en),
    .clear         (clear),
    .edge_valid    (edge_valid),
    .edge_mask     (edge_mask),
    .edge_stamp    (edge_stamp),
    .words_to_send (words_to_send),
    .rd_addr       (rd_addr),
    .limit_hit     (limit_hit),
    .words_written (words_written),
    .rd_mask       (rd_mask),
    .rd_stamp      (rd_stamp)
  );

endmodule

// ==== verilog/ddmtd_pkg.sv ====
package ddmtd_pkg;

  // ========================================
  // time stamp
  // ========================================

  // free running stamp counter width
  localparam int TS_WIDTH = 32;

  // one unsigned stamp per entry
  typedef logic [TS_WIDTH-1:0] stamp_t;

  // ========================================
  // power-up / capture sequencer
  // ========================================

  typedef enum logic [2:0] {
    // internal reset held
    SEQ_HOLD    = 3'd0,
    // reset released but sampling still off
    SEQ_SETTLE  = 3'd1,
    // sampling on but nothing written
    SEQ_ARMED   = 3'd2,
    // entries going into memory
    SEQ_CAPTURE = 3'd3,
    // word limit reached
    SEQ_DONE    = 3'd4
  } seq_state_t;

endpackage

// ==== verilog/ddmtd_sequencer.sv ====
`timescale 1ns/1ps

module ddmtd_sequencer #(
  parameter int SETTLE_CYCLES = 950000,
  parameter int ARM_CYCLES    = 50000
) (
  input  logic                  clk_ref,
  input  logic                  user_reset,
  input  logic                  capture_go,
  input  logic                  limit_hit,
  input  ddmtd_pkg::stamp_t     phase_count,
  output ddmtd_pkg::seq_state_t state,
  output logic                  phase_clear,
  output logic                  sampling_en,
  output logic                  write_en,
  output logic                  clear,
  output logic                  armed,
  output logic                  capturing,
  output logic                  capture_done
);

  import ddmtd_pkg::*;

  seq_state_t state_next;
  logic       hold_done;
  logic       settle_done;
  logic       go_dropped;

  // ========================================
  // phase ends
  // ========================================

  // phase counter restarts on every phase_clear so the last cycle is N-1
  assign hold_done   = (state == SEQ_HOLD) &&
                       (phase_count == stamp_t'(SETTLE_CYCLES - 1));
  assign settle_done = (state == SEQ_SETTLE) &&
                       (phase_count == stamp_t'(ARM_CYCLES - 1));

  // restart phase count at each power-up step
  assign phase_clear = hold_done || settle_done;

  // capture_go low while writing or finished
  assign go_dropped = ((state == SEQ_CAPTURE) || (state == SEQ_DONE)) && !capture_go;

  // ========================================
  // state register and next state
  // ========================================

  always_ff @(posedge clk_ref) begin
    if (user_reset) begin
      state <= SEQ_HOLD;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      SEQ_HOLD: begin
        if (hold_done) begin
          state_next = SEQ_SETTLE;
        end
      end
      SEQ_SETTLE: begin
        if (settle_done) begin
          state_next = SEQ_ARMED;
        end
      end
      SEQ_ARMED: begin
        if (capture_go) begin
          state_next = SEQ_CAPTURE;
        end
      end
      SEQ_CAPTURE: begin
        // dropping go wins over the limit
        if (!capture_go) begin
          state_next = SEQ_ARMED;
        end else if (limit_hit) begin
          state_next = SEQ_DONE;
        end
      end
      SEQ_DONE: begin
        if (!capture_go) begin
          state_next = SEQ_ARMED;
        end
      end
      default: begin
        state_next = SEQ_HOLD;
      end
    endcase
  end

  // ========================================
  // decoded controls
  // ========================================

  // stamp counter runs from armed onward
  assign sampling_en  = (state == SEQ_ARMED) || (state == SEQ_CAPTURE) ||
                        (state == SEQ_DONE);
  assign armed        = sampling_en;
  assign write_en     = (state == SEQ_CAPTURE);
  assign capturing    = write_en;
  assign capture_done = (state == SEQ_DONE);
  // one-cycle pulse that zeroes the writer count
  assign clear        = go_dropped;

  // done only entered from capture with the writer at its limit
  assert property (@(posedge clk_ref) disable iff (user_reset)
    $rose(capture_done) |-> $past((state == SEQ_CAPTURE) && limit_hit));

  // writing starts only from an armed cycle
  assert property (@(posedge clk_ref) disable iff (user_reset)
    $rose(write_en) |-> $past(armed));

endmodule

// ==== verilog/ddmtd_timebase.sv ====
`timescale 1ns/1ps

module ddmtd_timebase #(
  parameter int BEAT_HALF = 50000
) (
  input  logic                  clk_ref,
  input  logic                  user_reset,
  input  ddmtd_pkg::seq_state_t state,
  input  logic                  phase_clear,
  input  logic                  sampling_en,
  output ddmtd_pkg::stamp_t     phase_count,
  output ddmtd_pkg::stamp_t     stamp_now,
  output logic                  beat_ref
);

  import ddmtd_pkg::*;

  localparam int BEAT_W = $clog2(BEAT_HALF + 1);
  localparam logic [BEAT_W-1:0] BEAT_LAST = BEAT_W'(BEAT_HALF - 1);

  logic [BEAT_W-1:0] beat_cnt;

  // ========================================
  // sequencer phase counter
  // ========================================

  // counts cycles since reset or the last phase step
  always_ff @(posedge clk_ref) begin
    if (user_reset || phase_clear) begin
      phase_count <= '0;
    end else begin
      phase_count <= phase_count + 1'b1;
    end
  end

  // ========================================
  // time stamp counter
  // ========================================

  // held at zero until sampling turns on
  always_ff @(posedge clk_ref) begin
    if (user_reset || !sampling_en) begin
      stamp_now <= '0;
    end else begin
      stamp_now <= stamp_now + 1'b1;
    end
  end

  // ========================================
  // internal reference beat
  // ========================================

  // toggle every BEAT_HALF cycles and restart low on reset
  always_ff @(posedge clk_ref) begin
    if (user_reset) begin
      beat_cnt <= '0;
      beat_ref <= 1'b0;
    end else if (beat_cnt == BEAT_LAST) begin
      beat_cnt <= '0;
      beat_ref <= ~beat_ref;
    end else begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // no stamps can run before the sequencer arms
  assert property (@(posedge clk_ref) disable iff (user_reset)
    ((state == SEQ_HOLD) || (state == SEQ_SETTLE)) |-> (stamp_now == '0));

endmodule

// ==== verilog/edge_stamper.sv ====
`timescale 1ns/1ps

module edge_stamper #(
  parameter int NUM_CHANNELS = 5
) (
  input  logic                    clk_ref,
  input  logic                    user_reset,
  input  logic [NUM_CHANNELS-1:0] ddmtd_q,
  input  logic                    beat_ref,
  input  logic                    sampling_en,
  input  ddmtd_pkg::stamp_t       stamp_now,
  output logic                    edge_valid,
  output logic [NUM_CHANNELS:0]   edge_mask,
  output ddmtd_pkg::stamp_t       edge_stamp
);

  logic [NUM_CHANNELS-1:0] sync_meta;
  logic [NUM_CHANNELS-1:0] sync_q;
  logic [NUM_CHANNELS:0]   level_now;
  logic [NUM_CHANNELS:0]   level_prev;
  logic [NUM_CHANNELS:0]   rise;

  // ========================================
  // input synchronizers
  // ========================================

  // two flops per ddmtd flip-flop output
  always_ff @(posedge clk_ref) begin
    sync_meta <= ddmtd_q;
    sync_q    <= sync_meta;
  end

  // ========================================
  // rising edge detection
  // ========================================

  // beat already lives on clk_ref and takes the top mask bit
  assign level_now = {beat_ref, sync_q};

  always_ff @(posedge clk_ref) begin
    level_prev <= level_now;
  end

  assign rise = level_now & ~level_prev;

  // ========================================
  // stamp register
  // ========================================

  // edges while sampling is off are thrown away
  always_ff @(posedge clk_ref) begin
    if (user_reset) begin
      edge_valid <= 1'b0;
    end else begin
      edge_valid <= sampling_en && (rise != '0);
    end
  end

  // mask and stamp of the detection cycle
  always_ff @(posedge clk_ref) begin
    edge_mask  <= rise;
    edge_stamp <= stamp_now;
  end

  // every pulse names a channel and one held level never gives two pulses in a row
  assert property (@(posedge clk_ref) disable iff (user_reset)
    edge_valid |-> ((edge_mask != '0) &&
                    (!$past(edge_valid) || ((edge_mask & $past(edge_mask)) == '0))));

endmodule
